/* verilog/gpio_defs.svh */
`ifndef GPIO_DEFS_SVH
`define GPIO_DEFS_SVH

// ----------------------------------------
// pin count
// ----------------------------------------
`define GPIO_IO_NUM         32

// ----------------------------------------
// register map
// ----------------------------------------
// config registers sit below CFG_TOP, one word per pin
`define GPIO_ADDR_CFG_TOP   8'h80
`define GPIO_ADDR_INTR      8'h80
`define GPIO_ADDR_GPIN      8'h90
`define GPIO_ADDR_GPOUT     8'hA0

// ----------------------------------------
// config byte layout
// ----------------------------------------
`define GPIO_CFG_OUT_EN     0
`define GPIO_CFG_IN_EN      1
`define GPIO_CFG_OE_EN      2
`define GPIO_CFG_INT_EN     3
// interrupt mode in bits 7..5
`define GPIO_CFG_MODE_LSB   5

// output data register after reset
`define GPIO_GPOUT_RESET    32'h0000_00A5

`endif

/* verilog/gpio_pkg.sv */
`include "gpio_defs.svh"

`default_nettype none

package gpio_pkg;

   // one bit per pin
   typedef logic [`GPIO_IO_NUM-1:0] gpio_vec_t;

   // apb address and data
   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   // per-pin config byte
   typedef logic [7:0]  gpio_cfg_t;

   // ----------------------------------------
   // interrupt mode field, config bits 7..5
   // ----------------------------------------
   // codes 5 to 7 leave the pin without interrupt
   typedef enum logic [2:0] {
      IRQ_LEVEL_HIGH = 3'd0,
      IRQ_LEVEL_LOW  = 3'd1,
      IRQ_EDGE_POS   = 3'd2,
      IRQ_EDGE_NEG   = 3'd3,
      IRQ_EDGE_BOTH  = 3'd4
   } irq_mode_t;

endpackage

`default_nettype wire

/* verilog/gpio_input_sync.sv */
`include "gpio_defs.svh"

`default_nettype none

module gpio_input_sync
   import gpio_pkg::*;
(
   input  wire       PCLK,
   input  wire       aresetn,
   input  gpio_vec_t gpio_in_i,
   output gpio_vec_t sync_o,
   output gpio_vec_t prev_o
);

   gpio_vec_t stage1_q;
   gpio_vec_t stage2_q;
   gpio_vec_t stage3_q;

   // two flops against metastability, a third for edge history
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         stage1_q <= '0;
         stage2_q <= '0;
         stage3_q <= '0;
      end
      else
      begin
         stage1_q <= gpio_in_i;
         stage2_q <= stage1_q;
         stage3_q <= stage2_q;
      end
   end

   // an edge is seen while stage 2 and stage 3 differ
   assign sync_o = stage2_q;
   assign prev_o = stage3_q;

endmodule

`default_nettype wire

/* verilog/gpio_irq_logic.sv */
`include "gpio_defs.svh"

`default_nettype none

module gpio_irq_logic
   import gpio_pkg::*;
(
   input  wire       PCLK,
   input  wire       aresetn,
   input  gpio_cfg_t cfg_i [0:`GPIO_IO_NUM-1],
   input  gpio_vec_t sync_i,
   input  gpio_vec_t prev_i,
   input  wire       irq_clr_i,
   input  apb_data_t pwdata_i,
   output gpio_vec_t int_o,
   output gpio_vec_t intr_reg_o
);

   gpio_vec_t int_en;
   gpio_vec_t int_sel;
   gpio_vec_t rise;
   gpio_vec_t fall;
   gpio_vec_t any_edge;
   gpio_vec_t clr_mask;
   gpio_vec_t pos_q;
   gpio_vec_t neg_q;
   gpio_vec_t both_q;
   gpio_vec_t intr_q;

   // ----------------------------------------
   // edge events
   // ----------------------------------------
   assign rise     = sync_i & ~prev_i;
   assign fall     = ~sync_i & prev_i;
   assign any_edge = sync_i ^ prev_i;

   // write data is the clear mask, only during an INTR write
   assign clr_mask = irq_clr_i ? pwdata_i : '0;

   // ----------------------------------------
   // edge latches
   // ----------------------------------------
   // a new edge beats a clear in the same cycle
   // disabled pins keep all latches at 0
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         pos_q  <= '0;
         neg_q  <= '0;
         both_q <= '0;
      end
      else
      begin
         pos_q  <= int_en & (rise | (pos_q & ~clr_mask));
         neg_q  <= int_en & (fall | (neg_q & ~clr_mask));
         both_q <= int_en & (any_edge | (both_q & ~clr_mask));
      end
   end

   // ----------------------------------------
   // per-pin mode select
   // ----------------------------------------
   always_comb
   begin
      for (int i = 0; i < `GPIO_IO_NUM; i++)
      begin
         int_en[i] = cfg_i[i][`GPIO_CFG_INT_EN];
         case (irq_mode_t'(cfg_i[i][`GPIO_CFG_MODE_LSB +: 3]))
            IRQ_LEVEL_HIGH:
               int_sel[i] = prev_i[i];
            IRQ_LEVEL_LOW:
               int_sel[i] = ~prev_i[i];
            IRQ_EDGE_POS:
               int_sel[i] = pos_q[i];
            IRQ_EDGE_NEG:
               int_sel[i] = neg_q[i];
            IRQ_EDGE_BOTH:
               int_sel[i] = both_q[i];
            // codes 5..7
            default:
               int_sel[i] = 1'b0;
         endcase
      end
   end

   assign int_o = int_sel & int_en;

   // ----------------------------------------
   // readable interrupt register
   // ----------------------------------------
   // follows int_o one cycle late, masked bits drop on a clear write
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         intr_q <= '0;
      end
      else
      begin
         intr_q <= int_o & ~clr_mask;
      end
   end

   assign intr_reg_o = intr_q;

endmodule

`default_nettype wire

/* verilog/gpio_apb_regs.sv */
`include "gpio_defs.svh"

`default_nettype none

module gpio_apb_regs
   import gpio_pkg::*;
(
   input  wire       PCLK,
   input  wire       aresetn,
   input  wire       psel_i,
   input  wire       penable_i,
   input  wire       pwrite_i,
   input  apb_addr_t paddr_i,
   input  apb_data_t pwdata_i,
   output apb_data_t prdata_o,
   input  gpio_vec_t sync_i,
   input  gpio_vec_t intr_reg_i,
   output gpio_cfg_t cfg_o [0:`GPIO_IO_NUM-1],
   output logic      irq_clr_o,
   output gpio_vec_t gpio_out_o,
   output gpio_vec_t gpio_oe_o
);

   logic      wr_en;
   logic      cfg_sel;
   logic [5:0] cfg_idx;
   gpio_cfg_t cfg_q [0:`GPIO_IO_NUM-1];
   gpio_vec_t gpout_q;
   gpio_vec_t out_en;
   gpio_vec_t in_en;
   gpio_vec_t oe_en;

   // ----------------------------------------
   // write decode
   // ----------------------------------------
   // access phase, zero wait states
   assign wr_en   = psel_i & pwrite_i & penable_i;
   assign cfg_sel = (paddr_i < `GPIO_ADDR_CFG_TOP);
   assign cfg_idx = paddr_i[7:2];

   // clear strobe for the interrupt unit
   assign irq_clr_o = wr_en & (paddr_i == `GPIO_ADDR_INTR);

   // config bytes from the low data byte
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         for (int i = 0; i < `GPIO_IO_NUM; i++)
         begin
            cfg_q[i] <= '0;
         end
      end
      else if (wr_en && cfg_sel)
      begin
         cfg_q[cfg_idx[4:0]] <= pwdata_i[7:0];
      end
   end

   // output data register
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         gpout_q <= `GPIO_GPOUT_RESET;
      end
      else if (wr_en && (paddr_i == `GPIO_ADDR_GPOUT))
      begin
         gpout_q <= pwdata_i;
      end
   end

   // ----------------------------------------
   // per-pin enables and pin drive
   // ----------------------------------------
   always_comb
   begin
      for (int i = 0; i < `GPIO_IO_NUM; i++)
      begin
         out_en[i] = cfg_q[i][`GPIO_CFG_OUT_EN];
         in_en[i]  = cfg_q[i][`GPIO_CFG_IN_EN];
         oe_en[i]  = cfg_q[i][`GPIO_CFG_OE_EN];
      end
   end

   assign gpio_out_o = gpout_q & out_en;
   // oe only for pins that are outputs at all
   assign gpio_oe_o  = oe_en & out_en;

   assign cfg_o = cfg_q;

   // ----------------------------------------
   // read mux, combinational from paddr
   // ----------------------------------------
   always_comb
   begin
      prdata_o = '0;
      if (cfg_sel)
      begin
         prdata_o = apb_data_t'(cfg_q[cfg_idx[4:0]]);
      end
      else
      begin
         case (paddr_i)
            `GPIO_ADDR_INTR:
               prdata_o = intr_reg_i;
            `GPIO_ADDR_GPIN:
               prdata_o = sync_i & in_en;
            `GPIO_ADDR_GPOUT:
               prdata_o = gpout_q;
            default:
               prdata_o = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* verilog/gpio_top.sv */
`include "gpio_defs.svh"

`default_nettype none

module gpio_top
   import gpio_pkg::*;
(
   input  wire       PCLK,
   input  wire       aresetn,
   input  wire       psel_i,
   input  wire       penable_i,
   input  wire       pwrite_i,
   input  apb_addr_t paddr_i,
   input  apb_data_t pwdata_i,
   output apb_data_t prdata_o,
   output logic      pready_o,
   output logic      pslverr_o,
   output gpio_vec_t int_o,
   output logic      int_or_o,
   input  gpio_vec_t gpio_in_i,
   output gpio_vec_t gpio_out_o,
   output gpio_vec_t gpio_oe_o
);

   gpio_vec_t sync;
   gpio_vec_t prev;
   gpio_vec_t intr_reg;
   gpio_cfg_t cfg [0:`GPIO_IO_NUM-1];
   logic      irq_clr;

   // ----------------------------------------
   // input synchronizer
   // ----------------------------------------
   gpio_input_sync i_gpio_input_sync (
      .PCLK      (PCLK),
      .aresetn   (aresetn),
      .gpio_in_i (gpio_in_i),
      .sync_o    (sync),
      .prev_o    (prev)
   );

   // ----------------------------------------
   // interrupt unit
   // ----------------------------------------
   gpio_irq_logic i_gpio_irq_logic (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .cfg_i      (cfg),
      .sync_i     (sync),
      .prev_i     (prev),
      .irq_clr_i  (irq_clr),
      .pwdata_i   (pwdata_i),
      .int_o      (int_o),
      .intr_reg_o (intr_reg)
   );

   // ----------------------------------------
   // register file
   // ----------------------------------------
   gpio_apb_regs i_gpio_apb_regs (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .paddr_i    (paddr_i),
      .pwdata_i   (pwdata_i),
      .prdata_o   (prdata_o),
      .sync_i     (sync),
      .intr_reg_i (intr_reg),
      .cfg_o      (cfg),
      .irq_clr_o  (irq_clr),
      .gpio_out_o (gpio_out_o),
      .gpio_oe_o  (gpio_oe_o)
   );

   // no wait states, no error response
   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   assign int_or_o = |int_o;

endmodule

`default_nettype wire

/* bench/gpio_tb_asserts.sv */
`default_nettype none

module gpio_tb_asserts
   import gpio_pkg::*;
(
   input wire       PCLK,
   input wire       aresetn,
   input wire       pready_o,
   input wire       pslverr_o,
   input wire       int_or_o,
   input gpio_vec_t int_o
);

   timeunit 1ns;
   timeprecision 100ps;

   // number of failed assertions
   int fail_cnt = 0;

   // ----------------------------------------
   // bus response
   // ----------------------------------------
   ready_high: assert property (@(posedge PCLK) pready_o == 1'b1)
   else
   begin
      $error("pready_o is not tied high");
      fail_cnt++;
   end

   no_slverr: assert property (@(posedge PCLK) pslverr_o == 1'b0)
   else
   begin
      $error("pslverr_o is not tied low");
      fail_cnt++;
   end

   // ----------------------------------------
   // interrupt outputs
   // ----------------------------------------
   or_matches: assert property (@(posedge PCLK) disable iff (!aresetn)
      int_or_o == (|int_o))
   else
   begin
      $error("int_or_o differs from the OR of int_o");
      fail_cnt++;
   end

   // nothing may fire while reset is held
   quiet_in_reset: assert property (@(posedge PCLK) !aresetn |-> int_o == '0)
   else
   begin
      $error("int_o is not zero during reset");
      fail_cnt++;
   end

endmodule

bind gpio_top gpio_tb_asserts i_gpio_tb_asserts (
   .PCLK      (PCLK),
   .aresetn   (aresetn),
   .pready_o  (pready_o),
   .pslverr_o (pslverr_o),
   .int_or_o  (int_or_o),
   .int_o     (int_o)
);

`default_nettype wire

/* bench/gpio_tb.sv */
`include "gpio_defs.svh"

`default_nettype none

module gpio_tb
   import gpio_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   typedef enum logic [2:0] {
      OP_WR,
      OP_RD,
      OP_PINS,
      OP_WAIT_INT,
      OP_WAIT_RD,
      OP_OUT,
      OP_OE,
      OP_INT_OR
   } op_t;

   typedef struct {
      string     name;
      op_t       op;
      apb_addr_t addr;
      apb_data_t data;
      apb_data_t exp;
   } row_t;

   logic      PCLK;
   logic      aresetn;
   logic      psel_i;
   logic      penable_i;
   logic      pwrite_i;
   apb_addr_t paddr_i;
   apb_data_t pwdata_i;
   apb_data_t prdata_o;
   logic      pready_o;
   logic      pslverr_o;
   gpio_vec_t int_o;
   logic      int_or_o;
   gpio_vec_t gpio_in_i;
   gpio_vec_t gpio_out_o;
   gpio_vec_t gpio_oe_o;

   row_t      rows [$];
   gpio_cfg_t cfg_model [0:`GPIO_IO_NUM-1];
   int        checks;
   int        errors;
   int        timeouts;
   int        afails;

   gpio_top i_gpio_top (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .paddr_i    (paddr_i),
      .pwdata_i   (pwdata_i),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .pslverr_o  (pslverr_o),
      .int_o      (int_o),
      .int_or_o   (int_or_o),
      .gpio_in_i  (gpio_in_i),
      .gpio_out_o (gpio_out_o),
      .gpio_oe_o  (gpio_oe_o)
   );

   always #4 PCLK = ~PCLK;

   // ----------------------------------------
   // bus and pin tasks
   // ----------------------------------------
   task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
      @(posedge PCLK);
      psel_i    <= 1'b1;
      pwrite_i  <= 1'b1;
      paddr_i   <= addr;
      pwdata_i  <= data;
      @(posedge PCLK);
      penable_i <= 1'b1;
      @(posedge PCLK);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
      pwrite_i  <= 1'b0;
   endtask

   task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
      @(posedge PCLK);
      psel_i    <= 1'b1;
      pwrite_i  <= 1'b0;
      paddr_i   <= addr;
      @(posedge PCLK);
      penable_i <= 1'b1;
      @(negedge PCLK);
      data = prdata_o;
      @(posedge PCLK);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
   endtask

   task automatic drive_pins(input gpio_vec_t value);
      @(posedge PCLK);
      gpio_in_i <= value;
   endtask

   task automatic check_value(input string name, input apb_data_t exp, input apb_data_t act);
      checks++;
      assert (act == exp)
      else
      begin
         $display("Error: %s expected %08h actual %08h", name, exp, act);
         errors++;
      end
   endtask

   task automatic wait_for_int(input string name, input gpio_vec_t exp);
      bit seen;
      seen = 1'b0;
      for (int n = 0; n < 10 && !seen; n++)
      begin
         @(negedge PCLK);
         seen = (int_o == exp);
      end
      if (!seen)
      begin
         $display("Timeout: %s, int_o did not reach %08h within 10 cycles", name, exp);
         timeouts++;
      end
      check_value(name, exp, int_o);
   endtask

   // read data follows paddr without a transfer
   task automatic poll_reg(input string name, input apb_addr_t addr, input apb_data_t exp);
      bit seen;
      seen = 1'b0;
      @(posedge PCLK);
      paddr_i <= addr;
      for (int n = 0; n < 10 && !seen; n++)
      begin
         @(negedge PCLK);
         seen = (prdata_o == exp);
      end
      if (!seen)
      begin
         $display("Timeout: %s, register %02h did not settle within 10 cycles", name, addr);
         timeouts++;
      end
   endtask

   // ----------------------------------------
   // table construction
   // ----------------------------------------
   function automatic void add_row(input string name, input op_t op, input apb_addr_t addr,
                                   input apb_data_t data, input apb_data_t exp);
      row_t r;
      r.name = name;
      r.op   = op;
      r.addr = addr;
      r.data = data;
      r.exp  = exp;
      rows.push_back(r);
   endfunction

   // config write that also tracks the expected register contents
   function automatic void add_cfg(input int pin, input gpio_cfg_t value);
      cfg_model[pin] = value;
      add_row($sformatf("cfg%0d wr", pin), OP_WR, apb_addr_t'(pin * 4), {24'h0, value}, 32'h0);
   endfunction

   function automatic gpio_vec_t cfg_bits(input int pos);
      gpio_vec_t v;
      for (int i = 0; i < `GPIO_IO_NUM; i++)
      begin
         v[i] = cfg_model[i][pos];
      end
      return v;
   endfunction

   // mode in bits 7..5 and interrupt enable in bit 3
   function automatic gpio_cfg_t irq_cfg(input logic [2:0] mode, input logic en);
      return {mode, 1'b0, en, 3'b000};
   endfunction

   task automatic build_table();
      apb_data_t rnd;
      for (int i = 0; i < `GPIO_IO_NUM; i++)
      begin
         cfg_model[i] = 8'h00;
      end
      // reset values
      add_row("rst cfg0", OP_RD, 8'h00, 32'h0, 32'h0);
      add_row("rst cfg31", OP_RD, 8'h7C, 32'h0, 32'h0);
      add_row("rst gpout", OP_RD, `GPIO_ADDR_GPOUT, 32'h0, `GPIO_GPOUT_RESET);
      add_row("rst intr", OP_RD, `GPIO_ADDR_INTR, 32'h0, 32'h0);
      add_row("rst out", OP_OUT, 8'h00, 32'h0, 32'h0);
      add_row("rst oe", OP_OE, 8'h00, 32'h0, 32'h0);
      add_row("rst int", OP_WAIT_INT, 8'h00, 32'h0, 32'h0);
      // outputs on pins 0..7 with oe on the even ones and oe alone on pin 20
      for (int i = 0; i < 8; i++)
      begin
         add_cfg(i, (i % 2 == 0) ? 8'h05 : 8'h01);
      end
      add_cfg(20, 8'h04);
      add_row("gpout wr", OP_WR, `GPIO_ADDR_GPOUT, 32'h3C5A_F0C3, 32'h0);
      add_row("gpout rd", OP_RD, `GPIO_ADDR_GPOUT, 32'h0, 32'h3C5A_F0C3);
      add_row("cfg2 rd", OP_RD, 8'h08, 32'h0, 32'h0000_0005);
      add_row("pin out", OP_OUT, 8'h00, 32'h0, 32'h3C5A_F0C3 & cfg_bits(`GPIO_CFG_OUT_EN));
      add_row("pin oe", OP_OE, 8'h00, 32'h0,
              cfg_bits(`GPIO_CFG_OUT_EN) & cfg_bits(`GPIO_CFG_OE_EN));
      // input enable on even pins and random pin levels
      for (int i = 0; i < `GPIO_IO_NUM; i += 2)
      begin
         add_cfg(i, cfg_model[i] | 8'h02);
      end
      rnd = $urandom();
      add_row("pins rnd", OP_PINS, 8'h00, rnd, 32'h0);
      add_row("gpin settle", OP_WAIT_RD, `GPIO_ADDR_GPIN, 32'h0, rnd & cfg_bits(`GPIO_CFG_IN_EN));
      add_row("gpin rd", OP_RD, `GPIO_ADDR_GPIN, 32'h0, rnd & cfg_bits(`GPIO_CFG_IN_EN));
      add_row("unmapped 84", OP_RD, 8'h84, 32'h0, 32'h0);
      add_row("unmapped b0", OP_RD, 8'hB0, 32'h0, 32'h0);
      add_row("unmapped fc", OP_RD, 8'hFC, 32'h0, 32'h0);
      // level interrupts with pin 10 in mode 5
      add_row("pins low", OP_PINS, 8'h00, 32'h0, 32'h0);
      add_cfg(8, irq_cfg(IRQ_LEVEL_HIGH, 1'b1));
      add_cfg(9, irq_cfg(IRQ_LEVEL_LOW, 1'b1));
      add_cfg(10, irq_cfg(3'd5, 1'b1));
      add_row("lvl low", OP_WAIT_INT, 8'h00, 32'h0, 32'h0000_0200);
      add_row("pins 8-10 high", OP_PINS, 8'h00, 32'h0000_0700, 32'h0);
      add_row("lvl high", OP_WAIT_INT, 8'h00, 32'h0, 32'h0000_0100);
      add_row("lvl high or", OP_INT_OR, 8'h00, 32'h0, 32'h1);
      add_row("lvl high intr", OP_RD, `GPIO_ADDR_INTR, 32'h0, 32'h0000_0100);
      add_row("pin 9 high", OP_PINS, 8'h00, 32'h0000_0200, 32'h0);
      add_row("lvl none", OP_WAIT_INT, 8'h00, 32'h0, 32'h0);
      add_row("lvl none or", OP_INT_OR, 8'h00, 32'h0, 32'h0);
      add_row("lvl none intr", OP_RD, `GPIO_ADDR_INTR, 32'h0, 32'h0);
      // pin 9 low raises its level interrupt until the enable goes off
      add_row("pins clear", OP_PINS, 8'h00, 32'h0, 32'h0);
      for (int i = 8; i <= 10; i++)
      begin
         add_cfg(i, 8'h00);
      end
      add_row("lvl off", OP_WAIT_INT, 8'h00, 32'h0, 32'h0);
      // edge interrupts on pins 12..15
      add_cfg(12, irq_cfg(IRQ_EDGE_POS, 1'b1));
      add_cfg(13, irq_cfg(IRQ_EDGE_NEG, 1'b1));
      add_cfg(14, irq_cfg(IRQ_EDGE_BOTH, 1'b1));
      add_cfg(15, irq_cfg(IRQ_EDGE_POS, 1'b1));
      add_row("edge idle", OP_WAIT_INT, 8'h00, 32'h0, 32'h0);
      add_row("pins rise", OP_PINS, 8'h00, 32'h0000_F000, 32'h0);
      add_row("edge rise", OP_WAIT_INT, 8'h00, 32'h0, 32'h0000_D000);
      add_row("pins fall", OP_PINS, 8'h00, 32'h0, 32'h0);
      add_row("edge fall", OP_WAIT_INT, 8'h00, 32'h0, 32'h0000_F000);
      add_row("edge intr", OP_RD, `GPIO_ADDR_INTR, 32'h0, 32'h0000_F000);
      add_row("clr 12 14", OP_WR, `GPIO_ADDR_INTR, 32'h0000_5000, 32'h0);
      add_row("edge clr", OP_WAIT_INT, 8'h00, 32'h0, 32'h0000_A000);
      add_row("edge clr intr", OP_RD, `GPIO_ADDR_INTR, 32'h0, 32'h0000_A000);
      add_cfg(15, irq_cfg(IRQ_EDGE_POS, 1'b0));
      add_row("edge dis", OP_WAIT_INT, 8'h00, 32'h0, 32'h0000_2000);
      add_row("edge dis or", OP_INT_OR, 8'h00, 32'h0, 32'h1);
      add_row("clr 13", OP_WR, `GPIO_ADDR_INTR, 32'h0000_2000, 32'h0);
      add_row("edge all clr", OP_WAIT_INT, 8'h00, 32'h0, 32'h0);
      add_row("edge all clr or", OP_INT_OR, 8'h00, 32'h0, 32'h0);
   endtask

   // ----------------------------------------
   // row execution
   // ----------------------------------------
   task automatic run_row(input row_t r);
      apb_data_t rd;
      case (r.op)
         OP_WR:
            write_reg(r.addr, r.data);
         OP_RD:
         begin
            read_reg(r.addr, rd);
            check_value(r.name, r.exp, rd);
         end
         OP_PINS:
            drive_pins(r.data);
         OP_WAIT_INT:
            wait_for_int(r.name, r.exp);
         OP_WAIT_RD:
            poll_reg(r.name, r.addr, r.exp);
         OP_OUT:
         begin
            @(negedge PCLK);
            check_value(r.name, r.exp, gpio_out_o);
         end
         OP_OE:
         begin
            @(negedge PCLK);
            check_value(r.name, r.exp, gpio_oe_o);
         end
         OP_INT_OR:
         begin
            @(negedge PCLK);
            check_value(r.name, r.exp, {31'b0, int_or_o});
         end
      endcase
   endtask

   initial
   begin
      PCLK      = 1'b0;
      aresetn   = 1'b0;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = 8'h00;
      pwdata_i  = 32'h0;
      gpio_in_i = 32'h0;
      checks    = 0;
      errors    = 0;
      timeouts  = 0;
      void'($urandom(75));
      build_table();
      repeat (10) @(posedge PCLK);
      aresetn <= 1'b1;
      for (int k = 0; k < rows.size(); k++)
      begin
         run_row(rows[k]);
      end
      repeat (2) @(posedge PCLK);
      afails = i_gpio_top.i_gpio_tb_asserts.fail_cnt;
      $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
               checks, errors, timeouts, afails);
      if (errors == 0 && timeouts == 0 && afails == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/gpio_pkg.sv
verilog/gpio_input_sync.sv
verilog/gpio_irq_logic.sv
verilog/gpio_apb_regs.sv
verilog/gpio_top.sv
bench/gpio_tb_asserts.sv
bench/gpio_tb.sv

/* Makefile */
# Verilator simulation of the APB GPIO block

VERILATOR ?= verilator
TOP       ?= gpio_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
